//--- source/ps2_defines.svh
// ps2 host timing constants, expressed in microsecond and 100 us ticks
`ifndef PS2_DEFINES_SVH
`define PS2_DEFINES_SVH

//////////////////////////////
// tick division
//////////////////////////////
// qzt_clk cycles per 1 us tick (50 MHz)
`define PS2_US_DIV 50
// 1 us ticks per 100 us tick
`define PS2_100US_DIV 100

//////////////////////////////
// protocol intervals in us
//////////////////////////////
`define PS2_T_INHIBIT 120
`define PS2_T_DATA_LOW 60
`define PS2_T_HOLD 3
`define PS2_T_POSTACK 60
`define PS2_T_IDLE_CHECK 20

// abort limit, counted in 100 us ticks
`define PS2_T_WATCHDOG 20

// width of every timer limit
`define PS2_TIMER_W 8

`endif

//--- source/ps2_pkg.sv
// ps2 host types shared by the transmitter and its checks
package ps2_pkg;

	// transmitter FSM states, in protocol order
	typedef enum logic [3:0] {
		st_idle,
		st_inhibit,
		st_wait_fall,
		st_drive_bit,
		st_wait_last_rise,
		st_hold_last,
		st_wait_ack,
		st_post_ack,
		st_wait_idle
	} tx_state_t;

	// host to device frame, bit 0 goes out first
	typedef struct packed {
		logic       stop;
		logic       parity;
		logic [7:0] data;
		logic       start;
	} ps2_frame_t;

endpackage

//--- source/ps2_line_if.sv
// ps2 line bundle between the host transmitter and the pad block
`timescale 1ns/1ps

interface ps2_line_if;
	// 1 releases the line, 0 pulls it low
	logic clk_drive;
	logic data_drive;
	// single cycle strobes on the synchronized device clock
	logic clk_fall;
	logic clk_rise;
	// synchronized line levels
	logic clk_level;
	logic data_level;

	modport host (
		output clk_drive, data_drive,
		input  clk_fall, clk_rise, clk_level, data_level
	);

	modport pad (
		input  clk_drive, data_drive,
		output clk_fall, clk_rise, clk_level, data_level
	);
endinterface

//--- source/ps2_tick_gen.sv
// ps2 tick generator, single cycle 1 us and 100 us enables from qzt_clk
`timescale 1ns/1ps
`include "ps2_defines.svh"

module ps2_tick_gen (
	input  logic qzt_clk,
	input  logic rst,
	output logic us_tick,
	output logic hus_tick
);

	localparam int us_w = $clog2(`PS2_US_DIV);
	localparam int hus_w = $clog2(`PS2_100US_DIV);
	localparam logic [us_w-1:0] us_last = us_w'(`PS2_US_DIV - 1);
	localparam logic [hus_w-1:0] hus_last = hus_w'(`PS2_100US_DIV - 1);

	logic [us_w-1:0]  us_cnt;
	logic [hus_w-1:0] hus_cnt;

	// first stage counts clock cycles, second stage counts us ticks
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			us_cnt   <= '0;
			hus_cnt  <= '0;
			us_tick  <= 1'b0;
			hus_tick <= 1'b0;
		end else begin
			us_tick  <= 1'b0;
			hus_tick <= 1'b0;
			if (us_cnt == us_last) begin
				us_cnt  <= '0;
				us_tick <= 1'b1;
				// cascade, only advances on a full microsecond
				if (hus_cnt == hus_last) begin
					hus_cnt  <= '0;
					hus_tick <= 1'b1;
				end else begin
					hus_cnt <= hus_cnt + 1'b1;
				end
			end else begin
				us_cnt <= us_cnt + 1'b1;
			end
		end
	end

endmodule

//--- source/ps2_interval_timer.sv
// one-shot interval timer, pulses expire once after limit enable ticks
`timescale 1ns/1ps
`include "ps2_defines.svh"

module ps2_interval_timer (
	input  logic                    qzt_clk,
	input  logic                    rst,
	input  logic                    tick,
	input  logic                    run,
	input  logic [`PS2_TIMER_W-1:0] limit,
	output logic                    expire
);

	logic [`PS2_TIMER_W-1:0] count;
	// set after the pulse, keeps the timer silent until re-armed
	logic                    done;

	always_ff @(posedge qzt_clk) begin
		if (rst || !run) begin
			// run low clears everything, next rise re-arms
			count  <= '0;
			done   <= 1'b0;
			expire <= 1'b0;
		end else begin
			expire <= 1'b0;
			if (tick && !done) begin
				count <= count + 1'b1;
				// limit-th tick seen, expire lands on the next cycle
				if (count + 1'b1 == limit) begin
					expire <= 1'b1;
					done   <= 1'b1;
				end
			end
		end
	end

endmodule

//--- source/ps2_line_pad.sv
// ps2 pad block, open-drain drivers, line synchronizers and clock edge strobes
`timescale 1ns/1ps

module ps2_line_pad (
	input  logic   qzt_clk,
	input  logic   rst,
	inout  wire    ps2_clk,
	inout  wire    ps2_data,
	ps2_line_if.pad line
);

	logic clk_meta;
	logic clk_sync;
	logic clk_sync_d;
	logic data_meta;
	logic data_sync;

	// open drain, only ever pull low, the pull-up makes the high
	assign ps2_clk  = line.clk_drive ? 1'bz : 1'b0;
	assign ps2_data = line.data_drive ? 1'bz : 1'b0;

	//////////////////////////////
	// two flop synchronizers
	//////////////////////////////
	// idle bus reads high, so flops come out of reset at 1
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			clk_meta   <= 1'b1;
			clk_sync   <= 1'b1;
			clk_sync_d <= 1'b1;
			data_meta  <= 1'b1;
			data_sync  <= 1'b1;
		end else begin
			clk_meta   <= ps2_clk;
			clk_sync   <= clk_meta;
			clk_sync_d <= clk_sync;
			data_meta  <= ps2_data;
			data_sync  <= data_meta;
		end
	end

	// registered edge strobes, one cycle after the synchronized change
	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			line.clk_fall <= 1'b0;
			line.clk_rise <= 1'b0;
		end else begin
			line.clk_fall <= clk_sync_d & ~clk_sync;
			line.clk_rise <= ~clk_sync_d & clk_sync;
		end
	end

	assign line.clk_level  = clk_sync;
	assign line.data_level = data_sync;

endmodule

//--- source/ps2_host_tx.sv
// ps2 host transmit FSM, builds the frame, shifts it out and checks the ack
`timescale 1ns/1ps
`include "ps2_defines.svh"

module ps2_host_tx (
	input  logic                    qzt_clk,
	input  logic                    rst,
	input  logic [7:0]              data,
	input  logic                    send,
	ps2_line_if.host                line,
	input  logic                    us_tick,
	output logic                    prin_run,
	output logic [`PS2_TIMER_W-1:0] prin_limit,
	input  logic                    prin_expire,
	output logic                    aux_run,
	output logic [`PS2_TIMER_W-1:0] aux_limit,
	input  logic                    aux_expire,
	output logic                    wd_run,
	input  logic                    wd_expire,
	output logic                    ok,
	output logic                    err
);

	localparam logic [`PS2_TIMER_W-1:0] t_inhibit = `PS2_T_INHIBIT;
	localparam logic [`PS2_TIMER_W-1:0] t_data_low = `PS2_T_DATA_LOW;
	localparam logic [`PS2_TIMER_W-1:0] t_hold = `PS2_T_HOLD;
	localparam logic [`PS2_TIMER_W-1:0] t_postack = `PS2_T_POSTACK;
	localparam logic [`PS2_TIMER_W-1:0] t_idle_check = `PS2_T_IDLE_CHECK;

	ps2_pkg::tx_state_t state;
	ps2_pkg::ps2_frame_t frame;
	logic [10:0]        shift_q;
	logic [3:0]         bit_cnt;
	logic               send_d;
	logic               send_edge;
	logic               lines_high;

	// frame built straight from the input byte, odd parity over data
	always_comb begin
		frame.start  = 1'b0;
		frame.data   = data;
		frame.parity = ~^data;
		frame.stop   = 1'b1;
	end

	assign send_edge  = send & ~send_d;
	assign lines_high = line.clk_level & line.data_level;

	always_ff @(posedge qzt_clk) begin
		if (rst) begin
			state           <= ps2_pkg::st_idle;
			send_d          <= 1'b0;
			bit_cnt         <= '0;
			line.clk_drive  <= 1'b1;
			line.data_drive <= 1'b1;
			prin_run        <= 1'b0;
			prin_limit      <= '0;
			aux_run         <= 1'b0;
			aux_limit       <= '0;
			wd_run          <= 1'b0;
			ok              <= 1'b0;
			err             <= 1'b0;
		end else begin
			send_d <= send;
			ok     <= 1'b0;
			if (state != ps2_pkg::st_idle && wd_expire) begin
				// device never clocked, give the bus back and report
				line.clk_drive  <= 1'b1;
				line.data_drive <= 1'b1;
				prin_run        <= 1'b0;
				aux_run         <= 1'b0;
				wd_run          <= 1'b0;
				err             <= 1'b1;
				ok              <= 1'b1;
				state           <= ps2_pkg::st_idle;
			end else begin
				case (state)
					//////////////////////////////
					// request to send
					//////////////////////////////
					ps2_pkg::st_idle: begin
						// a send while busy never reaches here
						if (send_edge) begin
							shift_q        <= frame;
							bit_cnt        <= '0;
							err            <= 1'b0;
							line.clk_drive <= 1'b0;
							prin_limit     <= t_inhibit;
							prin_run       <= 1'b1;
							aux_limit      <= t_data_low;
							aux_run        <= 1'b1;
							wd_run         <= 1'b1;
							state          <= ps2_pkg::st_inhibit;
						end
					end
					ps2_pkg::st_inhibit: begin
						// data low midway, this is the start bit
						if (aux_expire) begin
							line.data_drive <= 1'b0;
							aux_run         <= 1'b0;
						end
						if (prin_expire) begin
							line.clk_drive <= 1'b1;
							prin_run       <= 1'b0;
							state          <= ps2_pkg::st_wait_fall;
						end
					end
					//////////////////////////////
					// bit shifting
					//////////////////////////////
					ps2_pkg::st_wait_fall: begin
						// device samples on rise, so change data on fall
						if (line.clk_fall) begin
							state <= ps2_pkg::st_drive_bit;
						end
					end
					ps2_pkg::st_drive_bit: begin
						line.data_drive <= shift_q[1];
						shift_q         <= {1'b1, shift_q[10:1]};
						bit_cnt         <= bit_cnt + 1'b1;
						// 8 data, parity and stop after the start bit
						if (bit_cnt == 4'd9) begin
							state <= ps2_pkg::st_wait_last_rise;
						end else begin
							state <= ps2_pkg::st_wait_fall;
						end
					end
					ps2_pkg::st_wait_last_rise: begin
						if (line.clk_rise) begin
							prin_limit <= t_hold;
							prin_run   <= 1'b1;
							state      <= ps2_pkg::st_hold_last;
						end
					end
					ps2_pkg::st_hold_last: begin
						// short hold past the stop bit, then free data for the ack
						if (prin_expire) begin
							prin_run        <= 1'b0;
							line.data_drive <= 1'b1;
							state           <= ps2_pkg::st_wait_ack;
						end
					end
					//////////////////////////////
					// ack and release
					//////////////////////////////
					ps2_pkg::st_wait_ack: begin
						// device holds data low for an ack, high means nack
						if (line.clk_fall) begin
							err        <= line.data_level;
							prin_limit <= t_postack;
							prin_run   <= 1'b1;
							state      <= ps2_pkg::st_post_ack;
						end
					end
					ps2_pkg::st_post_ack: begin
						if (prin_expire) begin
							prin_run   <= 1'b0;
							prin_limit <= t_idle_check;
							state      <= ps2_pkg::st_wait_idle;
						end
					end
					ps2_pkg::st_wait_idle: begin
						// restart the window whenever a us sample sees a low line
						if (!prin_run) begin
							prin_run <= 1'b1;
						end else if (us_tick && !lines_high) begin
							prin_run <= 1'b0;
						end
						if (prin_expire && lines_high) begin
							prin_run <= 1'b0;
							wd_run   <= 1'b0;
							ok       <= 1'b1;
							state    <= ps2_pkg::st_idle;
						end
					end
					default: begin
						state <= ps2_pkg::st_idle;
					end
				endcase
			end
		end
	end

endmodule

//--- source/ps2_host_top.sv
// ps2 host transmitter top, sends one command byte to a ps2 device
`timescale 1ns/1ps
`include "ps2_defines.svh"

module ps2_host_top (
	input  logic       qzt_clk,
	input  logic       rst,
	input  logic [7:0] data,
	input  logic       send,
	inout  wire        ps2_clk,
	inout  wire        ps2_data,
	output logic       ok,
	output logic       err
);

	localparam logic [`PS2_TIMER_W-1:0] wd_limit = `PS2_T_WATCHDOG;

	logic                    us_tick;
	logic                    hus_tick;
	logic                    prin_run;
	logic [`PS2_TIMER_W-1:0] prin_limit;
	logic                    prin_expire;
	logic                    aux_run;
	logic [`PS2_TIMER_W-1:0] aux_limit;
	logic                    aux_expire;
	logic                    wd_run;
	logic                    wd_expire;

	ps2_line_if line ();

	ps2_tick_gen u_tick_gen (
		.qzt_clk (qzt_clk),
		.rst     (rst),
		.us_tick (us_tick),
		.hus_tick(hus_tick)
	);

	// inhibit, hold, post-ack and idle intervals
	ps2_interval_timer u_prin_timer (
		.qzt_clk(qzt_clk),
		.rst    (rst),
		.tick   (us_tick),
		.run    (prin_run),
		.limit  (prin_limit),
		.expire (prin_expire)
	);

	// data low point inside the inhibit
	ps2_interval_timer u_aux_timer (
		.qzt_clk(qzt_clk),
		.rst    (rst),
		.tick   (us_tick),
		.run    (aux_run),
		.limit  (aux_limit),
		.expire (aux_expire)
	);

	// watchdog on the slow tick
	ps2_interval_timer u_wd_timer (
		.qzt_clk(qzt_clk),
		.rst    (rst),
		.tick   (hus_tick),
		.run    (wd_run),
		.limit  (wd_limit),
		.expire (wd_expire)
	);

	ps2_line_pad u_line_pad (
		.qzt_clk (qzt_clk),
		.rst     (rst),
		.ps2_clk (ps2_clk),
		.ps2_data(ps2_data),
		.line    (line.pad)
	);

	ps2_host_tx u_host_tx (
		.qzt_clk    (qzt_clk),
		.rst        (rst),
		.data       (data),
		.send       (send),
		.line       (line.host),
		.us_tick    (us_tick),
		.prin_run   (prin_run),
		.prin_limit (prin_limit),
		.prin_expire(prin_expire),
		.aux_run    (aux_run),
		.aux_limit  (aux_limit),
		.aux_expire (aux_expire),
		.wd_run     (wd_run),
		.wd_expire  (wd_expire),
		.ok         (ok),
		.err        (err)
	);

endmodule

//--- test/ps2_clock_gen.sv
// testbench clock and reset source, 20 ns qzt_clk with reset held for 5 cycles
`timescale 1ns/1ps

module ps2_clock_gen (
	output logic qzt_clk,
	output logic rst
);

	initial begin
		qzt_clk = 1'b0;
		forever #10 qzt_clk = ~qzt_clk;
	end

	// reset drops a little after the fifth rising edge
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge qzt_clk);
		#2;
		rst = 1'b0;
	end

endmodule

//--- test/ps2_device_model.sv
// behavioral ps2 device, clocks in a host frame and answers with ack, nack or nothing
`timescale 1ns/1ps

module ps2_device_model #(
	parameter int half_ns = 40000
) (
	inout  wire                 ps2_clk,
	inout  wire                 ps2_data,
	input  logic [1:0]          mode,
	output ps2_pkg::ps2_frame_t rx_frame,
	output int                  frame_count,
	output int                  inhibit_ns,
	output int                  lead_ns,
	output logic                data_low_at_release
);

	logic        clk_pull;
	logic        data_pull;
	time         low_t;
	time         data_fall_t;
	logic [10:0] bits;

	// open drain like the host, the pull-ups make the high
	assign ps2_clk  = clk_pull ? 1'b0 : 1'bz;
	assign ps2_data = data_pull ? 1'b0 : 1'bz;

	// last time data went low, the start bit before the clock release
	always @(negedge ps2_data) data_fall_t = $time;

	initial begin
		clk_pull            = 1'b0;
		data_pull           = 1'b0;
		frame_count         = 0;
		inhibit_ns          = 0;
		lead_ns             = 0;
		data_low_at_release = 1'b0;
		rx_frame            = '0;
		bits                = '0;
		data_fall_t         = 0;
		forever begin
			//////////////////////////////
			// request to send
			//////////////////////////////
			wait (ps2_clk === 1'b1);
			wait (ps2_clk === 1'b0);
			low_t = $time;
			wait (ps2_clk === 1'b1);
			inhibit_ns          = int'($time - low_t);
			lead_ns             = int'($time - data_fall_t);
			data_low_at_release = (ps2_data === 1'b0);
			// the release itself is the first rising edge, start bit
			bits[0] = ps2_data;
			// mode 2 never clocks, the host watchdog has to end it
			if (mode != 2'd2) begin
				#(half_ns);
				for (int i = 1; i < 11; i++) begin
					clk_pull = 1'b1;
					#(half_ns);
					clk_pull = 1'b0;
					// sample on the rise, host changed data on the fall
					bits[i] = ps2_data;
					#(half_ns);
				end
				rx_frame    = ps2_pkg::ps2_frame_t'(bits);
				frame_count = frame_count + 1;
				//////////////////////////////
				// ack pulse
				//////////////////////////////
				// data low ahead of the clock fall is an ack
				if (mode == 2'd0) begin
					data_pull = 1'b1;
				end
				#5000;
				clk_pull = 1'b1;
				#(half_ns);
				clk_pull = 1'b0;
				#5000;
				data_pull = 1'b0;
			end
		end
	end

endmodule

//--- test/ps2_host_tb.sv
// ps2 host transmitter testbench, file driven transfers against a device model
`timescale 1ns/1ps
`include "ps2_defines.svh"

module ps2_host_tb;

	logic                qzt_clk;
	logic                rst;
	logic [7:0]          data;
	logic                send;
	wire                 ps2_clk;
	wire                 ps2_data;
	logic                ok;
	logic                err;
	logic [1:0]          resp_mode;
	ps2_pkg::ps2_frame_t rx_frame;
	int                  frame_count;
	int                  inhibit_ns;
	int                  lead_ns;
	logic                data_low_at_release;

	logic [7:0] byte_q[$];
	int         mode_q[$];
	int         err_q[$];
	int         check_count = 0;
	int         error_count = 0;
	int         ok_count = 0;
	logic       ok_prev = 1'b0;
	int         cycle_count = 0;
	int         cycle_limit = 0;
	logic       timed_out = 1'b0;
	logic       setup_failed = 1'b0;

	ps2_clock_gen clock_gen (
		.qzt_clk(qzt_clk),
		.rst    (rst)
	);

	ps2_host_top dut (
		.qzt_clk (qzt_clk),
		.rst     (rst),
		.data    (data),
		.send    (send),
		.ps2_clk (ps2_clk),
		.ps2_data(ps2_data),
		.ok      (ok),
		.err     (err)
	);

	pullup (ps2_clk);
	pullup (ps2_data);

	ps2_device_model device (
		.ps2_clk            (ps2_clk),
		.ps2_data           (ps2_data),
		.mode               (resp_mode),
		.rx_frame           (rx_frame),
		.frame_count        (frame_count),
		.inhibit_ns         (inhibit_ns),
		.lead_ns            (lead_ns),
		.data_low_at_release(data_low_at_release)
	);

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timed_out);
		if (error_count == 0 && !timed_out && !setup_failed) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	// every ok is counted, and may never last two cycles
	always @(negedge qzt_clk) begin
		if (ok === 1'b1) begin
			check_value("ok high on the previous cycle", ok_prev, 0);
			ok_count++;
		end
		ok_prev = ok;
	end

	//////////////////////////////
	// one transfer
	//////////////////////////////
	task automatic run_transfer(input int idx);
		logic [7:0] b;
		int         frames_before;
		int         gap_us;
		b             = byte_q[idx];
		frames_before = frame_count;
		@(posedge qzt_clk);
		#2;
		data      = b;
		resp_mode = mode_q[idx][1:0];
		send      = 1'b1;
		@(posedge qzt_clk);
		#2;
		send = 1'b0;
		// a second request mid frame with other data must be ignored
		repeat (400 * `PS2_US_DIV) @(posedge qzt_clk);
		#2;
		data = ~b;
		send = 1'b1;
		@(posedge qzt_clk);
		#2;
		send = 1'b0;
		data = b;
		do @(negedge qzt_clk); while (ok !== 1'b1);
		check_value("err at ok", err, err_q[idx]);
		check_value("ps2_clk released at ok", ps2_clk, 1);
		check_value("ps2_data released at ok", ps2_data, 1);
		// channel taken for the full inhibit, data low well before release
		check_value("inhibit long enough", inhibit_ns >= (`PS2_T_INHIBIT - 1) * 1000, 1);
		check_value("data low before clock release", data_low_at_release, 1);
		check_value("data lead before release",
			lead_ns >= (`PS2_T_INHIBIT - `PS2_T_DATA_LOW - 1) * 1000, 1);
		if (mode_q[idx] == 2) begin
			check_value("frames seen without device clock", frame_count, frames_before);
		end else begin
			check_value("frames seen", frame_count, frames_before + 1);
			check_value("start bit", rx_frame.start, 0);
			check_value("data byte", rx_frame.data, b);
			// byte and parity together hold an odd number of ones
			check_value("odd parity", ^{b, rx_frame.parity}, 1);
			check_value("stop bit", rx_frame.stop, 1);
		end
		gap_us = $urandom_range(50, 0);
		repeat (gap_us * `PS2_US_DIV) @(posedge qzt_clk);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		int         fd;
		int         code;
		string      text;
		logic [7:0] b;
		int         m;
		int         e;
		logic       quiet;
		data      = 8'h00;
		send      = 1'b0;
		resp_mode = 2'd0;
		void'($urandom(26));
		fd = $fopen("test/ps2_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open test/ps2_testdata.txt, there is no stimulus to run");
			setup_failed = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(text, fd);
				// comment lines do not scan as three fields
				if (code != 0 && $sscanf(text, "%h %d %d", b, m, e) == 3) begin
					byte_q.push_back(b);
					mode_q.push_back(m);
					err_q.push_back(e);
				end
			end
			$fclose(fd);
		end
		if (byte_q.size() == 0) begin
			$display("the test data file holds no transfers");
			setup_failed = 1'b1;
		end
		// 3 ms per transfer covers the watchdog, plus reset and gaps
		cycle_limit = byte_q.size() * 3000 * `PS2_US_DIV + 20000;
		@(negedge rst);
		quiet = 1'b1;
		repeat (100) begin
			@(negedge qzt_clk);
			if (ok !== 1'b0 || err !== 1'b0 || ps2_clk !== 1'b1 || ps2_data !== 1'b1) begin
				quiet = 1'b0;
			end
		end
		check_value("quiet bus after reset", quiet, 1);
		for (int i = 0; i < byte_q.size(); i++) begin
			run_transfer(i);
		end
		check_value("ok pulse count", ok_count, byte_q.size());
		report_and_finish();
	end

	// cycle limit that ends a hung transfer
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge qzt_clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
		timed_out = 1'b1;
		report_and_finish();
	end

endmodule

//--- test/ps2_testdata.txt
# byte (hex), device response (0 ack, 1 nack, 2 no clock), expected err
# one transfer per line
ff 0 0
ed 0 0
00 0 0
a5 1 1
3c 0 0
f4 2 1
81 1 1
5a 0 0
f2 0 0

//--- filelist.f
+incdir+source
source/ps2_pkg.sv
source/ps2_line_if.sv
source/ps2_tick_gen.sv
source/ps2_interval_timer.sv
source/ps2_line_pad.sv
source/ps2_host_tx.sv
source/ps2_host_top.sv
test/ps2_clock_gen.sv
test/ps2_device_model.sv
test/ps2_host_tb.sv
